//--- source/bulk_cfg_pkg.sv
`default_nettype none

package bulk_cfg_pkg;

   // Largest packet on each bulk endpoint, in bytes.
   localparam int IN_MAX_PACKET = 8;
   localparam int OUT_MAX_PACKET = 8;

   // FIFO storage, two full packets per direction.
   localparam int IN_DEPTH = 16;
   localparam int OUT_DEPTH = 16;

   // Pointers carry one extra wrap bit to tell full from empty.
   localparam int IN_PTR_W = $clog2(IN_DEPTH) + 1;
   localparam int OUT_PTR_W = $clog2(OUT_DEPTH) + 1;

   // Byte count within one packet, wide enough for the larger endpoint.
   localparam int CNT_W =
      $clog2((IN_MAX_PACKET > OUT_MAX_PACKET ? IN_MAX_PACKET : OUT_MAX_PACKET) + 1);

endpackage

`default_nettype wire

//--- source/bulk_txn_pkg.sv
`default_nettype none

package bulk_txn_pkg;

   // Transaction controller states.
   // Only one IN or OUT transaction is in progress at a time.
   typedef enum logic [2:0] {
      IDLE        = 3'd0,
      IN_SEND     = 3'd1,
      IN_WAIT_ACK = 3'd2,
      OUT_RECV    = 3'd3,
      OUT_DROP    = 3'd4
   } endp_state_e;

   // One-cycle commands from the controller to a FIFO.
   // COMMIT makes the speculative pointer final.
   // REWIND returns the speculative pointer to the committed one.
   typedef enum logic [1:0] {
      CMD_NONE   = 2'd0,
      CMD_COMMIT = 2'd1,
      CMD_REWIND = 2'd2
   } fifo_cmd_e;

endpackage

`default_nettype wire

//--- source/bulk_in_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_in_fifo (
   input  logic                           app_clk_i,
   input  logic                           rstn,
   input  logic                           usb_reset_i,
   input  logic [7:0]                     app_in_data_i,
   input  logic                           app_in_valid_i,
   input  logic                           in_send_en_i,
   input  logic                           in_ready_i,
   input  bulk_txn_pkg::fifo_cmd_e        in_cmd_i,
   output logic                           app_in_ready_o,
   output logic [7:0]                     in_data_o,
   output logic                           in_valid_o,
   output logic [bulk_cfg_pkg::CNT_W-1:0] in_sent_cnt_o
);

   import bulk_cfg_pkg::*;
   import bulk_txn_pkg::*;

   // Byte storage.
   logic [7:0]          mem [IN_DEPTH];

   // Write pointer from the application side.
   logic [IN_PTR_W-1:0] wr_ptr;
   // Speculative read pointer, advanced per byte sent to the SIE.
   logic [IN_PTR_W-1:0] rd_ptr;
   // Committed read pointer, advanced only on a host ACK.
   logic [IN_PTR_W-1:0] cmt_ptr;

   // Next-cycle values used for the registered ready.
   logic [IN_PTR_W-1:0] wr_nxt;
   logic [IN_PTR_W-1:0] cmt_nxt;
   logic [IN_PTR_W-1:0] used_nxt;

   // Bytes sent in the current packet.
   logic [CNT_W-1:0]    sent_cnt;

   logic                ready_q;
   logic                push;
   logic                pop;

   // Application handshake.
   assign push = app_in_valid_i & ready_q;
   // SIE consumes a byte only while we offer one.
   assign pop = in_valid_o & in_ready_i;

   assign wr_nxt = wr_ptr + {{(IN_PTR_W-1){1'b0}}, push};
   assign cmt_nxt = (in_cmd_i == CMD_COMMIT) ? rd_ptr : cmt_ptr;

   // Space is measured against the committed pointer.
   // Unacknowledged bytes stay in place for a retry.
   assign used_nxt = wr_nxt - cmt_nxt;

   assign app_in_ready_o = ready_q;
   assign in_sent_cnt_o = sent_cnt;

   // Memory is read directly, so a byte written now is visible next cycle.
   assign in_data_o = mem[rd_ptr[IN_PTR_W-2:0]];

   // Offer data while sending, unsent bytes exist and the packet is not full.
   assign in_valid_o = in_send_en_i & (rd_ptr != wr_ptr) &
                       (sent_cnt < CNT_W'(IN_MAX_PACKET));

   // Storage write.
   always_ff @(posedge app_clk_i) begin
      if (push) begin
         mem[wr_ptr[IN_PTR_W-2:0]] <= app_in_data_i;
      end
   end

   // Pointers and packet count.
   always_ff @(posedge app_clk_i or negedge rstn) begin
      if (!rstn) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         cmt_ptr  <= '0;
         sent_cnt <= '0;
         ready_q  <= 1'b0;
      end else if (usb_reset_i) begin
         // Bus reset flushes everything, acknowledged or not.
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         cmt_ptr  <= '0;
         sent_cnt <= '0;
         ready_q  <= 1'b0;
      end else begin
         wr_ptr  <= wr_nxt;
         cmt_ptr <= cmt_nxt;
         // Ready is low whenever the next state would be full.
         ready_q <= (used_nxt != IN_PTR_W'(IN_DEPTH));

         // Rewind replays the packet from the last committed byte.
         if (in_cmd_i == CMD_REWIND) begin
            rd_ptr <= cmt_ptr;
         end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end

         // Either command closes the packet.
         if (in_cmd_i != CMD_NONE) begin
            sent_cnt <= '0;
         end else if (pop) begin
            sent_cnt <= sent_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/bulk_out_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_out_fifo (
   input  logic                    app_clk_i,
   input  logic                    rstn,
   input  logic                    usb_reset_i,
   input  logic [7:0]              out_data_i,
   input  logic                    out_valid_i,
   input  logic                    out_ready_i,
   input  logic                    out_wr_en_i,
   input  bulk_txn_pkg::fifo_cmd_e out_cmd_i,
   input  logic                    app_out_ready_i,
   output logic                    out_full_o,
   output logic [7:0]              app_out_data_o,
   output logic                    app_out_valid_o
);

   import bulk_cfg_pkg::*;
   import bulk_txn_pkg::*;

   // Byte storage.
   logic [7:0]           mem [OUT_DEPTH];

   // Speculative write pointer, advanced per byte from the SIE.
   logic [OUT_PTR_W-1:0] wr_ptr;
   // Committed write pointer, the limit for the application.
   logic [OUT_PTR_W-1:0] wr_cmt;
   logic [OUT_PTR_W-1:0] wr_cmt_nxt;
   // Read pointer of the output stage.
   logic [OUT_PTR_W-1:0] rd_ptr;
   // Bytes held, committed or not.
   logic [OUT_PTR_W-1:0] fill;

   // Bytes written in the current packet.
   logic [CNT_W-1:0]     pkt_cnt;

   // Output register.
   logic [7:0]           data_q;
   logic                 valid_q;

   logic                 wr_stb;
   logic                 load;

   assign fill = wr_ptr - rd_ptr;
   assign out_full_o = (fill == OUT_PTR_W'(OUT_DEPTH));

   // Bytes past the packet size limit are ignored.
   assign wr_stb = out_wr_en_i & out_ready_i & out_valid_i &
                   ~out_full_o & (pkt_cnt < CNT_W'(OUT_MAX_PACKET));

   // A commit is seen by the output stage in the same cycle.
   // This saves one cycle of latency to the application.
   assign wr_cmt_nxt = (out_cmd_i == CMD_COMMIT) ? wr_ptr : wr_cmt;

   // Refill the output register when empty or being consumed.
   assign load = (rd_ptr != wr_cmt_nxt) & (~valid_q | app_out_ready_i);

   assign app_out_data_o = data_q;
   assign app_out_valid_o = valid_q;

   // Storage write.
   always_ff @(posedge app_clk_i) begin
      if (wr_stb) begin
         mem[wr_ptr[OUT_PTR_W-2:0]] <= out_data_i;
      end
   end

   // Output data.
   always_ff @(posedge app_clk_i) begin
      if (load) begin
         data_q <= mem[rd_ptr[OUT_PTR_W-2:0]];
      end
   end

   // Pointers, packet count and output valid.
   always_ff @(posedge app_clk_i or negedge rstn) begin
      if (!rstn) begin
         wr_ptr  <= '0;
         wr_cmt  <= '0;
         rd_ptr  <= '0;
         pkt_cnt <= '0;
         valid_q <= 1'b0;
      end else if (usb_reset_i) begin
         wr_ptr  <= '0;
         wr_cmt  <= '0;
         rd_ptr  <= '0;
         pkt_cnt <= '0;
         valid_q <= 1'b0;
      end else begin
         wr_cmt <= wr_cmt_nxt;

         // Rewind drops every byte of the packet.
         if (out_cmd_i == CMD_REWIND) begin
            wr_ptr <= wr_cmt;
         end else if (wr_stb) begin
            wr_ptr <= wr_ptr + 1'b1;
         end

         // A commit starts a new packet; a byte in the same cycle belongs to it.
         if (out_cmd_i == CMD_REWIND) begin
            pkt_cnt <= '0;
         end else if (out_cmd_i == CMD_COMMIT) begin
            pkt_cnt <= {{(CNT_W-1){1'b0}}, wr_stb};
         end else if (wr_stb) begin
            pkt_cnt <= pkt_cnt + 1'b1;
         end

         if (load) begin
            rd_ptr  <= rd_ptr + 1'b1;
            valid_q <= 1'b1;
         end else if (app_out_ready_i) begin
            valid_q <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/bulk_endp_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_endp_ctrl (
   input  logic                           app_clk_i,
   input  logic                           rstn,
   input  logic                           usb_reset_i,
   input  logic                           in_req_i,
   input  logic                           in_data_ack_i,
   input  logic                           out_valid_i,
   input  logic                           out_err_i,
   input  logic                           out_ready_i,
   input  logic                           out_full_i,
   input  logic [bulk_cfg_pkg::CNT_W-1:0] in_sent_cnt_i,
   output logic                           in_send_en_o,
   output bulk_txn_pkg::fifo_cmd_e        in_cmd_o,
   output bulk_txn_pkg::fifo_cmd_e        out_cmd_o,
   output logic                           out_wr_en_o,
   output logic                           out_nak_o
);

   import bulk_cfg_pkg::*;
   import bulk_txn_pkg::*;

   endp_state_e state_q;
   endp_state_e state_d;
   fifo_cmd_e   in_cmd_d;
   fifo_cmd_e   out_cmd_d;

   logic        in_req_q;
   logic        nak_q;

   // Decoded SIE strobes.
   logic        in_req_rise;
   logic        ack_stb;
   logic        byte_stb;
   logic        err_stb;
   logic        end_stb;

   // IN starts on the rising edge only, so a request still high after ACK is ignored.
   assign in_req_rise = in_req_i & ~in_req_q;

   // out_ready_i qualifies every SIE event.
   // An abort wins over a byte.
   assign ack_stb  = out_ready_i & in_data_ack_i;
   assign err_stb  = out_ready_i & out_err_i;
   assign byte_stb = out_ready_i & out_valid_i & ~out_err_i;
   assign end_stb  = out_ready_i & ~out_valid_i & ~out_err_i & ~in_data_ack_i;

   assign in_send_en_o = (state_q == IN_SEND);
   assign out_nak_o = nak_q;

   // The first byte is written while still in IDLE.
   assign out_wr_en_o = (state_q == OUT_RECV) | ((state_q == IDLE) & ~out_full_i);

   always_comb begin
      state_d   = state_q;
      in_cmd_d  = CMD_NONE;
      out_cmd_d = CMD_NONE;
      case (state_q)
         IDLE: begin
            if (in_req_rise) begin
               state_d = IN_SEND;
            end else if (byte_stb) begin
               state_d = out_full_i ? OUT_DROP : OUT_RECV;
            end
         end
         IN_SEND, IN_WAIT_ACK: begin
            // ACK keeps the sent bytes and a request ending without it replays them.
            if (ack_stb) begin
               in_cmd_d = CMD_COMMIT;
               state_d  = IDLE;
            end else if (!in_req_i) begin
               in_cmd_d = CMD_REWIND;
               state_d  = IDLE;
            end else if ((state_q == IN_SEND) &&
                         (in_sent_cnt_i == CNT_W'(IN_MAX_PACKET))) begin
               state_d = IN_WAIT_ACK;
            end
         end
         OUT_RECV: begin
            if (err_stb) begin
               out_cmd_d = CMD_REWIND;
               state_d   = IDLE;
            end else if (end_stb) begin
               out_cmd_d = CMD_COMMIT;
               state_d   = IDLE;
            end else if (byte_stb && out_full_i) begin
               // Packet no longer fits and the rest is thrown away.
               state_d = OUT_DROP;
            end
         end
         OUT_DROP: begin
            if (err_stb || end_stb) begin
               out_cmd_d = CMD_REWIND;
               state_d   = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge app_clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q   <= IDLE;
         in_cmd_o  <= CMD_NONE;
         out_cmd_o <= CMD_NONE;
         in_req_q  <= 1'b0;
         nak_q     <= 1'b0;
      end else if (usb_reset_i) begin
         state_q   <= IDLE;
         in_cmd_o  <= CMD_NONE;
         out_cmd_o <= CMD_NONE;
         in_req_q  <= 1'b0;
         nak_q     <= 1'b0;
      end else begin
         state_q   <= state_d;
         in_cmd_o  <= in_cmd_d;
         out_cmd_o <= out_cmd_d;
         in_req_q  <= in_req_i;
         // NAK follows the FIFO state seen by each byte.
         if (byte_stb) begin
            nak_q <= out_full_i;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/bulk_endp.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_endp (
   input  logic       app_clk_i,
   input  logic       rstn,
   input  logic       usb_reset_i,
   input  logic [7:0] app_in_data_i,
   input  logic       app_in_valid_i,
   output logic       app_in_ready_o,
   output logic [7:0] app_out_data_o,
   output logic       app_out_valid_o,
   input  logic       app_out_ready_i,
   input  logic       in_req_i,
   input  logic       in_ready_i,
   input  logic       in_data_ack_i,
   output logic [7:0] in_data_o,
   output logic       in_valid_o,
   input  logic [7:0] out_data_i,
   input  logic       out_valid_i,
   input  logic       out_err_i,
   input  logic       out_ready_i,
   output logic       out_nak_o
);

   import bulk_cfg_pkg::*;
   import bulk_txn_pkg::*;

   // Controller to FIFO commands.
   fifo_cmd_e        in_cmd;
   fifo_cmd_e        out_cmd;
   logic             in_send_en;
   logic             out_wr_en;
   // FIFO status back to the controller.
   logic [CNT_W-1:0] in_sent_cnt;
   logic             out_full;

   bulk_endp_ctrl u_ctrl (
      .app_clk_i     (app_clk_i),
      .rstn          (rstn),
      .usb_reset_i   (usb_reset_i),
      .in_req_i      (in_req_i),
      .in_data_ack_i (in_data_ack_i),
      .out_valid_i   (out_valid_i),
      .out_err_i     (out_err_i),
      .out_ready_i   (out_ready_i),
      .out_full_i    (out_full),
      .in_sent_cnt_i (in_sent_cnt),
      .in_send_en_o  (in_send_en),
      .in_cmd_o      (in_cmd),
      .out_cmd_o     (out_cmd),
      .out_wr_en_o   (out_wr_en),
      .out_nak_o     (out_nak_o)
   );

   // Application to SIE path.
   bulk_in_fifo u_in_fifo (
      .app_clk_i      (app_clk_i),
      .rstn           (rstn),
      .usb_reset_i    (usb_reset_i),
      .app_in_data_i  (app_in_data_i),
      .app_in_valid_i (app_in_valid_i),
      .in_send_en_i   (in_send_en),
      .in_ready_i     (in_ready_i),
      .in_cmd_i       (in_cmd),
      .app_in_ready_o (app_in_ready_o),
      .in_data_o      (in_data_o),
      .in_valid_o     (in_valid_o),
      .in_sent_cnt_o  (in_sent_cnt)
   );

   // SIE to application path.
   bulk_out_fifo u_out_fifo (
      .app_clk_i       (app_clk_i),
      .rstn            (rstn),
      .usb_reset_i     (usb_reset_i),
      .out_data_i      (out_data_i),
      .out_valid_i     (out_valid_i),
      .out_ready_i     (out_ready_i),
      .out_wr_en_i     (out_wr_en),
      .out_cmd_i       (out_cmd),
      .app_out_ready_i (app_out_ready_i),
      .out_full_o      (out_full),
      .app_out_data_o  (app_out_data_o),
      .app_out_valid_o (app_out_valid_o)
   );

endmodule

`default_nettype wire

//--- verification/bulk_endp_chk.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_endp_chk (
   input logic       app_clk_i,
   input logic       rstn,
   input logic       in_req_i,
   input logic       in_valid_i,
   input logic       app_in_ready_i,
   input logic [7:0] app_out_data_i,
   input logic       app_out_valid_i,
   input logic       app_out_ready_i,
   input logic       out_nak_i
);

   // Failed assertions, read by the testbench for the verdict.
   int assert_fails = 0;

   // A withdrawn IN request ends the offer within one cycle.
   a_in_valid_drop: assert property (@(posedge app_clk_i) disable iff (!rstn)
      (!in_req_i && !$past(in_req_i)) |-> !in_valid_i)
   else begin
      $error("in_valid_o high after in_req_i was low for a cycle");
      assert_fails++;
   end

   // A stalled output byte must not change.
   a_out_hold: assert property (@(posedge app_clk_i) disable iff (!rstn)
      (app_out_valid_i && !app_out_ready_i) |=> (app_out_valid_i && $stable(app_out_data_i)))
   else begin
      $error("app_out_valid_o or app_out_data_o changed under back-pressure");
      assert_fails++;
   end

   // Status outputs are low while reset is applied.
   a_reset_low: assert property (@(posedge app_clk_i)
      !rstn |-> (!in_valid_i && !app_out_valid_i && !out_nak_i && !app_in_ready_i))
   else begin
      $error("Output high during reset");
      assert_fails++;
   end

endmodule

bind bulk_endp bulk_endp_chk chk0 (
   .app_clk_i       (app_clk_i),
   .rstn            (rstn),
   .in_req_i        (in_req_i),
   .in_valid_i      (in_valid_o),
   .app_in_ready_i  (app_in_ready_o),
   .app_out_data_i  (app_out_data_o),
   .app_out_valid_i (app_out_valid_o),
   .app_out_ready_i (app_out_ready_i),
   .out_nak_i       (out_nak_o)
);

`default_nettype wire

//--- verification/bulk_endp_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_endp_monitor (
   input  logic       app_clk_i,
   input  logic       rstn,
   input  logic [7:0] app_in_data_i,
   input  logic       app_in_valid_i,
   input  logic       app_in_ready_i,
   input  logic [7:0] app_out_data_i,
   input  logic       app_out_valid_i,
   input  logic       app_out_ready_i,
   input  logic       in_req_i,
   input  logic       in_ready_i,
   input  logic       in_data_ack_i,
   input  logic [7:0] in_data_i,
   input  logic       in_valid_i,
   input  logic [7:0] out_data_i,
   input  logic       out_valid_i,
   input  logic       out_err_i,
   input  logic       out_ready_i,
   input  logic       out_nak_i,
   output int         err_cnt_o,
   output int         in_left_o,
   output int         out_left_o
);

   import bulk_cfg_pkg::*;

   // IN model of every byte written, with a send index and a committed index.
   logic [7:0] in_q [$];
   int         in_rd = 0;
   int         in_cmt = 0;
   int         in_pkt = 0;
   logic       in_busy = 1'b0;
   logic       in_req_q = 1'b0;
   // OUT model of the bytes owed to the application and the packet in progress.
   logic [7:0] out_q [$];
   logic [7:0] pkt_q [$];
   logic       out_busy = 1'b0;
   logic       out_drop = 1'b0;
   logic       want_nak = 1'b0;
   logic       full;
   logic [7:0] want;
   int         errs = 0;
   int         in_left = 0;
   int         out_left = 0;

   assign err_cnt_o = errs;
   assign in_left_o = in_left;
   assign out_left_o = out_left;

   always @(posedge app_clk_i) begin
      if (!rstn) begin
         in_q.delete();
         out_q.delete();
         pkt_q.delete();
         in_rd = 0;
         in_cmt = 0;
         in_busy = 1'b0;
         out_busy = 1'b0;
         want_nak = 1'b0;
      end else begin
         // The byte in the output register takes no storage space.
         full = (out_q.size() + pkt_q.size() - int'(app_out_valid_i)) >= OUT_DEPTH;
         if (out_nak_i !== want_nak) begin
            $display("ERR %0t out_nak_o expected %b got %b", $time, want_nak, out_nak_i);
            errs++;
         end
         // Unacknowledged bytes fill the IN FIFO until the host ACKs them.
         if ((in_q.size() - in_cmt >= IN_DEPTH) && (app_in_ready_i !== 1'b0)) begin
            $display("ERR %0t app_in_ready_o expected 0 got %b", $time, app_in_ready_i);
            errs++;
         end
         if (app_in_valid_i && app_in_ready_i) begin
            in_q.push_back(app_in_data_i);
         end
         // Each SIE strobe takes the next unsent byte.
         if (in_valid_i && in_ready_i) begin
            if (in_rd >= in_q.size()) begin
               $display("Error at %0t: IN byte sent that the application never wrote", $time);
               errs++;
            end else if (in_data_i !== in_q[in_rd]) begin
               $display("ERR %0t in_data_o expected %02h got %02h", $time, in_q[in_rd],
                        in_data_i);
               errs++;
            end
            in_rd++;
            in_pkt++;
            if (in_pkt == IN_MAX_PACKET + 1) begin
               $display("Error at %0t: IN packet longer than %0d bytes", $time, IN_MAX_PACKET);
               errs++;
            end
         end
         // ACK keeps the sent bytes and a dropped request replays them.
         if (in_busy && out_ready_i && in_data_ack_i) begin
            in_cmt = in_rd;
            in_busy = 1'b0;
         end else if (in_busy && !in_req_i) begin
            in_rd = in_cmt;
            in_busy = 1'b0;
         end
         if (in_req_i && !in_req_q) begin
            in_busy = 1'b1;
            in_pkt = 0;
         end
         // OUT strobes. Once a byte meets a full FIFO the packet is lost.
         if (out_ready_i && out_valid_i && !out_err_i) begin
            if (!out_busy) begin
               out_busy = 1'b1;
               out_drop = 1'b0;
            end
            want_nak = full;
            if (full) begin
               out_drop = 1'b1;
            end else if (!out_drop) begin
               pkt_q.push_back(out_data_i);
            end
         end else if (out_busy && out_ready_i && out_err_i) begin
            pkt_q.delete();
            out_busy = 1'b0;
         end else if (out_busy && out_ready_i && !in_data_ack_i) begin
            if (!out_drop) begin
               foreach (pkt_q[i]) out_q.push_back(pkt_q[i]);
            end
            pkt_q.delete();
            out_busy = 1'b0;
         end
         if (app_out_valid_i && app_out_ready_i) begin
            if (out_q.size() == 0) begin
               $display("Error at %0t: application got an OUT byte that was not due", $time);
               errs++;
            end else begin
               want = out_q.pop_front();
               if (app_out_data_i !== want) begin
                  $display("ERR %0t app_out_data_o expected %02h got %02h", $time, want,
                           app_out_data_i);
                  errs++;
               end
            end
         end
      end
      in_req_q = in_req_i;
      in_left = in_q.size() - in_cmt;
      out_left = out_q.size();
   end

endmodule

`default_nettype wire

//--- verification/bulk_endp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_endp_tb;

   localparam int ACT_WR = 0;
   localparam int ACT_IN = 1;
   localparam int ACT_OUT = 2;
   localparam int ACT_RD = 3;
   localparam int N_ROWS = 24;
   localparam int RST_CYCLES = 5;

   // Columns are action, byte count, flag and idle cycles before the row.
   // Flag means ACK for IN, abort for OUT, stalls for reads, full check for writes.
   int tbl [N_ROWS][4] = '{
      '{ACT_WR, 10, 0, 1},
      '{ACT_IN, 8, 0, 1},
      '{ACT_IN, 8, 1, 1},
      '{ACT_IN, 8, 1, 1},
      // With more than one packet queued the next IN stops at the size limit.
      '{ACT_WR, 12, 0, 1},
      '{ACT_IN, 10, 1, 1},
      '{ACT_IN, 8, 1, 1},
      // Fill the IN FIFO so that only an ACK makes room.
      '{ACT_WR, 16, 1, 1},
      '{ACT_IN, 8, 1, 1},
      '{ACT_WR, 4, 0, 1},
      '{ACT_IN, 8, 0, 2},
      '{ACT_IN, 8, 1, 1},
      '{ACT_IN, 8, 1, 1},
      '{ACT_OUT, 6, 0, 1},
      '{ACT_RD, 6, 1, 1},
      // An aborted packet and then a clean one.
      '{ACT_OUT, 5, 1, 1},
      '{ACT_OUT, 7, 0, 2},
      '{ACT_RD, 7, 0, 1},
      // Two packets fill the OUT FIFO and the third is NAKed.
      '{ACT_OUT, 8, 0, 1},
      '{ACT_OUT, 8, 0, 1},
      '{ACT_OUT, 4, 0, 1},
      '{ACT_RD, 16, 1, 2},
      '{ACT_OUT, 3, 0, 1},
      '{ACT_RD, 3, 0, 1}
   };

   logic        app_clk_i = 1'b0;
   logic        rstn = 1'b1;
   logic        usb_reset_i = 1'b0;
   logic [7:0]  app_in_data_i = 8'h00;
   logic        app_in_valid_i = 1'b0;
   logic        app_in_ready_o;
   logic [7:0]  app_out_data_o;
   logic        app_out_valid_o;
   logic        app_out_ready_i = 1'b0;
   logic        in_req_i = 1'b0;
   logic        in_ready_i = 1'b0;
   logic        in_data_ack_i = 1'b0;
   logic [7:0]  in_data_o;
   logic        in_valid_o;
   logic [7:0]  out_data_i = 8'h00;
   logic        out_valid_i = 1'b0;
   logic        out_err_i = 1'b0;
   logic        out_ready_i = 1'b0;
   logic        out_nak_o;
   int          mon_errs;
   int          in_left;
   int          out_left;
   int          tb_errs = 0;
   int          cycle_cnt = 0;
   int          cycle_limit = 0;
   logic [31:0] rand_state = 32'd39999;

   always #20 app_clk_i = ~app_clk_i;

   bulk_endp dut0 (.*);

   bulk_endp_monitor mon0 (
      .app_clk_i, .rstn, .app_in_data_i, .app_in_valid_i,
      .app_in_ready_i (app_in_ready_o),
      .app_out_data_i (app_out_data_o),
      .app_out_valid_i (app_out_valid_o),
      .app_out_ready_i, .in_req_i, .in_ready_i, .in_data_ack_i,
      .in_data_i (in_data_o),
      .in_valid_i (in_valid_o),
      .out_data_i, .out_valid_i, .out_err_i, .out_ready_i,
      .out_nak_i (out_nak_o),
      .err_cnt_o (mon_errs),
      .in_left_o (in_left),
      .out_left_o (out_left)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // Time budget grows with the bytes moved by each row.
   function automatic int run_limit();
      int sum;
      sum = RST_CYCLES;
      for (int r = 0; r < N_ROWS; r++) sum += 4 * tbl[r][1] + 10;
      return sum;
   endfunction

   // Inputs change 2 ns after the rising edge.
   task automatic next_cycle();
      @(posedge app_clk_i);
      #2;
   endtask

   task automatic print_counts();
      $display("Error counts: monitor %0d, testbench %0d, assertions %0d",
               mon_errs, tb_errs, dut0.chk0.assert_fails);
   endtask

   task automatic app_write(input int count, input int check_full);
      logic taken;
      for (int i = 0; i < count; i++) begin
         rand_state = lcg_next(rand_state);
         app_in_data_i = rand_state[23:16];
         app_in_valid_i = 1'b1;
         taken = 1'b0;
         // Ready is registered, so its value now decides the next edge.
         while (!taken) begin
            taken = app_in_ready_o;
            next_cycle();
         end
      end
      app_in_valid_i = 1'b0;
      if (check_full != 0) begin
         repeat (3) next_cycle();
         if (app_in_ready_o !== 1'b0) begin
            $display("ERR %0t app_in_ready_o expected 0 got %b", $time, app_in_ready_o);
            tb_errs++;
         end
      end
   endtask

   task automatic in_transaction(input int count, input int ack);
      int sent;
      sent = 0;
      in_req_i = 1'b1;
      next_cycle();
      for (int c = 0; c < count + 4; c++) begin
         in_ready_i = in_valid_o && (sent < count);
         if (in_ready_i) sent++;
         next_cycle();
      end
      in_ready_i = 1'b0;
      if (ack != 0) begin
         in_data_ack_i = 1'b1;
         out_ready_i = 1'b1;
         next_cycle();
         in_data_ack_i = 1'b0;
         out_ready_i = 1'b0;
      end
      in_req_i = 1'b0;
      repeat (3) next_cycle();
   endtask

   task automatic out_packet(input int count, input int abort);
      for (int i = 0; i < count; i++) begin
         rand_state = lcg_next(rand_state);
         out_data_i = rand_state[23:16];
         out_valid_i = 1'b1;
         out_ready_i = 1'b1;
         next_cycle();
         out_valid_i = 1'b0;
         out_ready_i = 1'b0;
         next_cycle();
      end
      // Closing strobe for an abort or a clean end.
      out_err_i = (abort != 0);
      out_ready_i = 1'b1;
      next_cycle();
      out_err_i = 1'b0;
      out_ready_i = 1'b0;
      repeat (3) next_cycle();
   endtask

   task automatic app_read(input int count, input int stall);
      int   got;
      logic take;
      got = 0;
      while (got < count) begin
         rand_state = lcg_next(rand_state);
         app_out_ready_i = (stall == 0) || (rand_state[17:16] != 2'b00);
         take = app_out_valid_o && app_out_ready_i;
         next_cycle();
         if (take) got++;
      end
      app_out_ready_i = 1'b0;
   endtask

   always @(posedge app_clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout: the run did not end within %0d cycles", cycle_limit);
         print_counts();
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      cycle_limit = run_limit();
      #1 rstn = 1'b0;
      repeat (RST_CYCLES) @(posedge app_clk_i);
      #2 rstn = 1'b1;
      for (int r = 0; r < N_ROWS; r++) begin
         repeat (tbl[r][3]) next_cycle();
         case (tbl[r][0])
            ACT_WR: app_write(tbl[r][1], tbl[r][2]);
            ACT_IN: in_transaction(tbl[r][1], tbl[r][2]);
            ACT_OUT: out_packet(tbl[r][1], tbl[r][2]);
            default: app_read(tbl[r][1], tbl[r][2]);
         endcase
      end
      repeat (4) next_cycle();
      if (in_left != 0) begin
         $display("Error: %0d IN bytes were never acknowledged", in_left);
         tb_errs++;
      end
      if (out_left != 0) begin
         $display("Error: %0d OUT bytes never reached the application", out_left);
         tb_errs++;
      end
      print_counts();
      if (mon_errs + tb_errs + dut0.chk0.assert_fails == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
source/bulk_cfg_pkg.sv
source/bulk_txn_pkg.sv
source/bulk_in_fifo.sv
source/bulk_out_fifo.sv
source/bulk_endp_ctrl.sv
source/bulk_endp.sv
verification/bulk_endp_chk.sv
verification/bulk_endp_monitor.sv
verification/bulk_endp_tb.sv
